// File: verilog/core_pkg.sv
package core_pkg;

  //////////////////////////////
  // widths
  localparam int data_width     = 32;
  localparam int inst_width     = 32;
  localparam int reg_addr_width = 5;
  localparam int imm_width      = 16;
  localparam int shamt_width    = 5;

  //////////////////////////////
  // instruction fields
  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 26;
  localparam int rs_msb     = 25;
  localparam int rs_lsb     = 21;
  localparam int rt_msb     = 20;
  localparam int rt_lsb     = 16;
  localparam int rd_msb     = 15;
  localparam int rd_lsb     = 11;
  localparam int shamt_msb  = 10;
  localparam int shamt_lsb  = 6;
  localparam int imm_msb    = 15;
  localparam int imm_lsb    = 0;

  // r-type first, then the immediate forms
  typedef enum logic [5:0] {
    op_nop  = 6'h00,
    op_add  = 6'h01,
    op_sub  = 6'h02,
    op_and  = 6'h03,
    op_or   = 6'h04,
    op_xor  = 6'h05,
    op_slt  = 6'h06,
    op_sll  = 6'h07,
    op_addi = 6'h08,
    op_ori  = 6'h09,
    op_xori = 6'h0a
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll
  } alu_op_t;

  //////////////////////////////
  // stage payloads
  typedef struct packed {
    logic                      valid;
    logic                      reg_write;
    logic                      reg_dst;
    logic                      alu_src;
    alu_op_t                   alu_op;
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rt;
    logic [reg_addr_width-1:0] rd;
    logic [shamt_width-1:0]    shamt;
    logic [imm_width-1:0]      imm;
    logic [data_width-1:0]     rs_data;
    logic [data_width-1:0]     rt_data;
  } id_ex_t;

  typedef struct packed {
    logic                      valid;
    logic                      reg_write;
    logic [reg_addr_width-1:0] dst;
    logic [data_width-1:0]     result;
  } ex_wb_t;

  typedef struct packed {
    logic                      valid;
    logic [reg_addr_width-1:0] rd;
    logic [data_width-1:0]     data;
  } retire_t;

endpackage

// File: verilog/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t d,
  output payload_t q
);

  // whole payload cleared so the stage comes up empty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else begin
      q <= d;
    end
  end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps

module register_file
  import core_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [reg_addr_width-1:0] rs_addr,
  input  logic [reg_addr_width-1:0] rt_addr,
  output logic [data_width-1:0]     rs_data,
  output logic [data_width-1:0]     rt_data,
  input  ex_wb_t                    wb
);

  logic [data_width-1:0] regs [1:31];
  logic                  wb_write;

  assign wb_write = wb.valid && wb.reg_write && (wb.dst != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_write) begin
      regs[wb.dst] <= wb.result;
    end
  end

  // r0 reads zero, a write in flight is seen straight away
  function automatic logic [data_width-1:0] read_reg(input logic [reg_addr_width-1:0] addr);
    if (addr == '0) begin
      return '0;
    end
    if (wb_write && (wb.dst == addr)) begin
      return wb.result;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs_data = read_reg(rs_addr);
    rt_data = read_reg(rt_addr);
  end

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
  import core_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      inst_valid,
  input  logic [inst_width-1:0]     inst,
  output logic [reg_addr_width-1:0] rs_addr,
  output logic [reg_addr_width-1:0] rt_addr,
  input  logic [data_width-1:0]     rs_data,
  input  logic [data_width-1:0]     rt_data,
  output id_ex_t                    id_ex
);

  logic                      if_valid;
  logic [inst_width-1:0]     if_inst;
  opcode_t                   opcode;
  logic [reg_addr_width-1:0] rd;
  logic [reg_addr_width-1:0] dst;
  logic                      known;
  logic                      reg_dst;
  logic                      alu_src;
  alu_op_t                   alu_op;
  id_ex_t                    id_next;

  //////////////////////////////
  // fetch/decode register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_valid <= 1'b0;
      if_inst  <= '0;
    end else begin
      if_valid <= inst_valid;
      if_inst  <= inst;
    end
  end

  assign opcode  = opcode_t'(if_inst[opcode_msb:opcode_lsb]);
  assign rs_addr = if_inst[rs_msb:rs_lsb];
  assign rt_addr = if_inst[rt_msb:rt_lsb];
  assign rd      = if_inst[rd_msb:rd_lsb];

  //////////////////////////////
  // opcode control
  always_comb begin
    known   = 1'b1;
    reg_dst = 1'b1;
    alu_src = 1'b0;
    alu_op  = alu_add;
    case (opcode)
      op_add: alu_op = alu_add;
      op_sub: alu_op = alu_sub;
      op_and: alu_op = alu_and;
      op_or:  alu_op = alu_or;
      op_xor: alu_op = alu_xor;
      op_slt: alu_op = alu_slt;
      op_sll: alu_op = alu_sll;
      op_addi, op_ori, op_xori: begin
        reg_dst = 1'b0;
        alu_src = 1'b1;
        alu_op  = (opcode == op_addi) ? alu_add : (opcode == op_ori) ? alu_or : alu_xor;
      end
      // nop and undefined codes
      default: known = 1'b0;
    endcase
  end

  assign dst = reg_dst ? rd : rt_addr;

  always_comb begin
    id_next.valid     = if_valid;
    id_next.reg_write = known && (dst != '0);
    id_next.reg_dst   = reg_dst;
    id_next.alu_src   = alu_src;
    id_next.alu_op    = alu_op;
    id_next.rs        = rs_addr;
    id_next.rt        = rt_addr;
    id_next.rd        = rd;
    id_next.shamt     = if_inst[shamt_msb:shamt_lsb];
    id_next.imm       = if_inst[imm_msb:imm_lsb];
    id_next.rs_data   = rs_data;
    id_next.rt_data   = rt_data;
  end

  pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
    .clk   (clk),
    .rst_n (rst_n),
    .d     (id_next),
    .q     (id_ex)
  );

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu
  import core_pkg::*;
(
  input  alu_op_t                alu_op,
  input  logic [data_width-1:0]  a,
  input  logic [data_width-1:0]  b,
  input  logic [shamt_width-1:0] shamt,
  output logic [data_width-1:0]  result
);

  logic less;

  // signed compare
  assign less = $signed(a) < $signed(b);

  always_comb begin
    case (alu_op)
      alu_add: begin
        result = a + b;
      end
      alu_sub: begin
        result = a - b;
      end
      alu_and: begin
        result = a & b;
      end
      alu_or: begin
        result = a | b;
      end
      alu_xor: begin
        result = a ^ b;
      end
      alu_slt: begin
        result = {{(data_width-1){1'b0}}, less};
      end
      // shifts the rt operand, as in the r-type sll
      alu_sll: begin
        result = b << shamt;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
  import core_pkg::*;
(
  input  id_ex_t id_ex,
  input  ex_wb_t wb,
  output ex_wb_t ex_result
);

  logic                      wb_write;
  logic                      fwd_rs;
  logic                      fwd_rt;
  logic [data_width-1:0]     op_a;
  logic [data_width-1:0]     rt_val;
  logic [data_width-1:0]     op_b;
  logic [data_width-1:0]     imm_ext;
  logic [reg_addr_width-1:0] dst;
  logic [data_width-1:0]     alu_result;

  //////////////////////////////
  // forwarding from wb
  assign wb_write = wb.valid && wb.reg_write && (wb.dst != '0);
  assign fwd_rs   = wb_write && (wb.dst == id_ex.rs);
  assign fwd_rt   = wb_write && (wb.dst == id_ex.rt);

  assign op_a   = fwd_rs ? wb.result : id_ex.rs_data;
  assign rt_val = fwd_rt ? wb.result : id_ex.rt_data;

  // immediates are zero extended
  assign imm_ext = {{(data_width-imm_width){1'b0}}, id_ex.imm};
  assign op_b    = id_ex.alu_src ? imm_ext : rt_val;

  // rd for r-type, rt for immediate forms
  assign dst = id_ex.reg_dst ? id_ex.rd : id_ex.rt;

  alu i_alu (
    .alu_op (id_ex.alu_op),
    .a      (op_a),
    .b      (op_b),
    .shamt  (id_ex.shamt),
    .result (alu_result)
  );

  always_comb begin
    ex_result.valid     = id_ex.valid;
    ex_result.reg_write = id_ex.reg_write;
    ex_result.dst       = dst;
    ex_result.result    = alu_result;
  end

endmodule

// File: verilog/mini_core.sv
`timescale 1ns/1ps

module mini_core
  import core_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  inst_valid,
  input  logic [inst_width-1:0] inst,
  output retire_t               retire
);

  id_ex_t                    id_ex;
  ex_wb_t                    ex_result;
  ex_wb_t                    wb;
  logic [reg_addr_width-1:0] rs_addr;
  logic [reg_addr_width-1:0] rt_addr;
  logic [data_width-1:0]     rs_data;
  logic [data_width-1:0]     rt_data;

  decode_stage i_decode_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .rs_addr    (rs_addr),
    .rt_addr    (rt_addr),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .id_ex      (id_ex)
  );

  register_file i_register_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wb      (wb)
  );

  execute_stage i_execute_stage (
    .id_ex     (id_ex),
    .wb        (wb),
    .ex_result (ex_result)
  );

  //////////////////////////////
  // writeback
  pipe_reg #(.payload_t(ex_wb_t)) ex_wb (
    .clk   (clk),
    .rst_n (rst_n),
    .d     (ex_result),
    .q     (wb)
  );

  // every register write shows up here
  assign retire = '{valid: wb.valid && wb.reg_write, rd: wb.dst, data: wb.result};

endmodule

// File: test/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int half_period = 50;
  localparam int reset_cycles = 3;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // released on a falling edge, clear of the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: test/core_properties.sv
`timescale 1ns/1ps

module core_properties
  import core_pkg::*;
(
  input logic                  clk,
  input logic                  rst_n,
  input logic                  inst_valid,
  input logic [inst_width-1:0] inst,
  input retire_t               retire
);

  int unsigned               fail_count = 0;
  opcode_t                   op;
  logic                      imm_form;
  logic                      r_form;
  logic [reg_addr_width-1:0] dst;
  logic                      writes;

  assign op       = opcode_t'(inst[opcode_msb:opcode_lsb]);
  assign imm_form = op inside {op_addi, op_ori, op_xori};
  assign r_form   = op inside {op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sll};
  assign dst      = imm_form ? inst[rt_msb:rt_lsb] : inst[rd_msb:rd_lsb];
  assign writes   = (imm_form || r_form) && (dst != '0);

  //////////////////////////////
  // reset
  reset_quiet: assert property (@(posedge clk) !rst_n |-> !retire.valid)
    else begin
      fail_count++;
      $error("retire valid while in reset");
    end

  first_cycle_quiet: assert property (@(posedge clk) $rose(rst_n) |=> !retire.valid)
    else begin
      fail_count++;
      $error("retire valid in the first cycle after reset");
    end

  //////////////////////////////
  // retire port
  no_rd_zero: assert property (@(posedge clk) disable iff (!rst_n)
    retire.valid |-> retire.rd != '0)
    else begin
      fail_count++;
      $error("retire shows r0 as destination");
    end

  data_known: assert property (@(posedge clk) disable iff (!rst_n)
    retire.valid |-> !$isunknown(retire.data))
    else begin
      fail_count++;
      $error("retire data has unknown bits");
    end

  // three edges from sampling to a visible result
  write_retires: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid && writes |-> ##3 retire.valid)
    else begin
      fail_count++;
      $error("writing instruction did not retire after 3 cycles");
    end

endmodule

bind mini_core core_properties i_core_properties (
  .clk        (clk),
  .rst_n      (rst_n),
  .inst_valid (inst_valid),
  .inst       (inst),
  .retire     (retire)
);

// File: test/core_tb.sv
`timescale 1ns/1ps

module core_tb
  import core_pkg::*;
();

  localparam int retire_latency = 3;
  localparam int retire_timeout = 6;
  localparam int reset_timeout  = 10;
  localparam int drain_timeout  = 12;
  localparam int idle_cycles    = 6;
  localparam int random_count   = 200;

  logic                  clk;
  logic                  rst_n;
  logic                  inst_valid;
  logic [inst_width-1:0] inst;
  retire_t               retire;

  integer                seed;
  int                    cycle;
  logic [data_width-1:0] ref_regs [0:31];

  // stimulus table
  string                     tbl_name [$];
  logic [inst_width-1:0]     tbl_inst [$];
  int                        tbl_valid [$];
  logic [reg_addr_width-1:0] tbl_rd [$];
  logic [data_width-1:0]     tbl_data [$];
  int                        tbl_gap [$];

  // writes still in flight
  string                     exp_name_q [$];
  logic [reg_addr_width-1:0] exp_rd_q [$];
  logic [data_width-1:0]     exp_data_q [$];
  int                        exp_cycle_q [$];

  clock_gen i_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mini_core i_mini_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .retire     (retire)
  );

  task automatic fail(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("Regression failed");
      $fatal(1, "stopped at the first error");
    end
  endtask

  //////////////////////////////
  // encoders and table
  function automatic logic [inst_width-1:0] enc_r(input logic [5:0] op, input int rs,
                                                  input int rt, input int rd, input int shamt);
    logic [inst_width-1:0] w;
    w = '0;
    w[opcode_msb:opcode_lsb] = op;
    w[rs_msb:rs_lsb]         = rs[4:0];
    w[rt_msb:rt_lsb]         = rt[4:0];
    w[rd_msb:rd_lsb]         = rd[4:0];
    w[shamt_msb:shamt_lsb]   = shamt[4:0];
    return w;
  endfunction

  function automatic logic [inst_width-1:0] enc_i(input logic [5:0] op, input int rs,
                                                  input int rt, input logic [15:0] imm);
    logic [inst_width-1:0] w;
    w = '0;
    w[opcode_msb:opcode_lsb] = op;
    w[rs_msb:rs_lsb]         = rs[4:0];
    w[rt_msb:rt_lsb]         = rt[4:0];
    w[imm_msb:imm_lsb]       = imm;
    return w;
  endfunction

  task automatic add_row(input string name, input logic [inst_width-1:0] word, input int valid,
                         input int rd, input logic [data_width-1:0] data, input int gap);
    tbl_name.push_back(name);
    tbl_inst.push_back(word);
    tbl_valid.push_back(valid);
    tbl_rd.push_back(rd[4:0]);
    tbl_data.push_back(data);
    tbl_gap.push_back(gap);
  endtask

  task automatic load_table();
    // independent operations with gaps between them
    add_row("addi", enc_i(op_addi, 0, 1, 16'h1234), 1, 1, 32'h0000_1234, 3);
    add_row("ori", enc_i(op_ori, 0, 2, 16'hf0f0), 1, 2, 32'h0000_f0f0, 3);
    add_row("xori", enc_i(op_xori, 0, 3, 16'hffff), 1, 3, 32'h0000_ffff, 3);
    add_row("add", enc_r(op_add, 1, 2, 4, 0), 1, 4, 32'h0001_0324, 3);
    add_row("sub", enc_r(op_sub, 2, 1, 5, 0), 1, 5, 32'h0000_debc, 3);
    add_row("and", enc_r(op_and, 2, 3, 6, 0), 1, 6, 32'h0000_f0f0, 3);
    add_row("or", enc_r(op_or, 1, 2, 7, 0), 1, 7, 32'h0000_f2f4, 3);
    add_row("xor", enc_r(op_xor, 1, 3, 8, 0), 1, 8, 32'h0000_edcb, 3);
    add_row("sub to negative a", enc_r(op_sub, 0, 1, 9, 0), 1, 9, 32'hffff_edcc, 3);
    add_row("sub to negative b", enc_r(op_sub, 0, 3, 10, 0), 1, 10, 32'hffff_0001, 3);
    add_row("slt both negative", enc_r(op_slt, 10, 9, 11, 0), 1, 11, 32'h1, 3);
    add_row("slt false", enc_r(op_slt, 9, 10, 12, 0), 1, 12, 32'h0, 3);
    add_row("slt negative vs positive", enc_r(op_slt, 9, 1, 13, 0), 1, 13, 32'h1, 3);
    add_row("sll", enc_r(op_sll, 0, 1, 14, 4), 1, 14, 32'h0001_2340, 3);
    // back to back chain through wb
    add_row("forward seed", enc_i(op_addi, 0, 15, 16'h0001), 1, 15, 32'd1, 0);
    add_row("forward rs and rt", enc_r(op_add, 15, 15, 15, 0), 1, 15, 32'd2, 0);
    add_row("forward again", enc_r(op_add, 15, 15, 15, 0), 1, 15, 32'd4, 0);
    add_row("forward sll rt", enc_r(op_sll, 0, 15, 16, 3), 1, 16, 32'd32, 0);
    add_row("forward and write-through", enc_r(op_sub, 16, 15, 17, 0), 1, 17, 32'd28, 0);
    add_row("forward immediate", enc_i(op_addi, 17, 18, 16'h0010), 1, 18, 32'h2c, 0);
    add_row("write-through and stored", enc_r(op_or, 17, 16, 19, 0), 1, 19, 32'h3c, 0);
    add_row("write-through after forward", enc_r(op_xor, 18, 15, 20, 0), 1, 20, 32'h28, 1);
    add_row("write-through across gap", enc_r(op_add, 20, 19, 21, 0), 1, 21, 32'h64, 2);
    add_row("stored across gap", enc_r(op_sub, 21, 20, 22, 0), 1, 22, 32'h3c, 3);
    // r0, unknown opcode and nop never write
    add_row("addi to r0", enc_i(op_addi, 0, 0, 16'h0055), 0, 0, 32'h0, 0);
    add_row("r0 not forwarded", enc_r(op_add, 0, 15, 23, 0), 1, 23, 32'd4, 0);
    add_row("add to r0", enc_r(op_add, 1, 2, 0, 0), 0, 0, 32'h0, 0);
    add_row("r0 not written through", enc_i(op_ori, 0, 24, 16'h0007), 1, 24, 32'd7, 0);
    add_row("unknown opcode", enc_r(6'h3f, 1, 2, 25, 0), 0, 0, 32'h0, 0);
    add_row("nop", enc_r(op_nop, 1, 2, 26, 0), 0, 0, 32'h0, 0);
    add_row("unwritten registers", enc_r(op_or, 25, 26, 27, 0), 1, 27, 32'h0, 3);
  endtask

  //////////////////////////////
  // reference model
  task automatic model_exec(input logic [inst_width-1:0] word, output logic writes,
                            output logic [reg_addr_width-1:0] dst,
                            output logic [data_width-1:0] value);
    logic [5:0]            op;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    logic [data_width-1:0] zimm;
    op     = word[opcode_msb:opcode_lsb];
    a      = ref_regs[word[rs_msb:rs_lsb]];
    b      = ref_regs[word[rt_msb:rt_lsb]];
    zimm   = {16'h0000, word[imm_msb:imm_lsb]};
    dst    = word[rd_msb:rd_lsb];
    writes = 1'b1;
    value  = '0;
    case (op)
      op_add:  value = a + b;
      op_sub:  value = a - b;
      op_and:  value = a & b;
      op_or:   value = a | b;
      op_xor:  value = a ^ b;
      op_slt:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      op_sll:  value = b << word[shamt_msb:shamt_lsb];
      op_addi: value = a + zimm;
      op_ori:  value = a | zimm;
      op_xori: value = a ^ zimm;
      default: writes = 1'b0;
    endcase
    if (op == op_addi || op == op_ori || op == op_xori) begin
      dst = word[rt_msb:rt_lsb];
    end
    if (dst == '0) begin
      writes = 1'b0;
    end
    if (writes) begin
      ref_regs[dst] = value;
    end
  endtask

  // mostly writing opcodes on r0..r7 for dense dependencies
  function automatic logic [inst_width-1:0] random_inst();
    logic [31:0] r;
    logic [31:0] f;
    logic [5:0]  op;
    int          pick;
    r    = $random(seed);
    f    = $random(seed);
    pick = $unsigned(r) % 24;
    op   = (pick < 22) ? 6'(pick % 11) : 6'h3f;
    if (op == op_addi || op == op_ori || op == op_xori) begin
      return enc_i(op, int'(f[2:0]), int'(f[5:3]), f[31:16]);
    end
    return enc_r(op, int'(f[2:0]), int'(f[5:3]), int'(f[8:6]), int'(f[13:9]));
  endfunction

  //////////////////////////////
  // driving and scoreboard
  task automatic expect_retire(input string name, input logic [reg_addr_width-1:0] rd,
                               input logic [data_width-1:0] data);
    exp_name_q.push_back(name);
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(data);
    exp_cycle_q.push_back(cycle);
  endtask

  task automatic check_retire();
    string name;
    if (retire.valid === 1'b1 && exp_rd_q.size() == 0) begin
      fail($sformatf("a retire to r%0d arrived with no write outstanding", retire.rd));
    end else if (retire.valid === 1'b1) begin
      name = exp_name_q.pop_front();
      check({name, " rd"}, {27'b0, exp_rd_q.pop_front()}, {27'b0, retire.rd});
      check({name, " data"}, exp_data_q.pop_front(), retire.data);
      check({name, " latency"}, retire_latency, cycle - exp_cycle_q.pop_front());
    end else if (retire.valid !== 1'b0) begin
      fail("retire valid is unknown");
    end else if (exp_rd_q.size() != 0 && cycle - exp_cycle_q[0] >= retire_timeout) begin
      fail({"no retire arrived for ", exp_name_q[0]});
    end
  endtask

  // sample the retire port, then drive the next input
  task automatic step(input logic valid, input logic [inst_width-1:0] word);
    @(negedge clk);
    cycle++;
    check_retire();
    inst_valid = valid;
    inst       = word;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_rd_q.size() != 0 && waited < drain_timeout) begin
      step(1'b0, '0);
      waited++;
    end
    if (exp_rd_q.size() != 0) begin
      fail({"no retire arrived for ", exp_name_q[0], " before the pipeline drained"});
    end
  endtask

  initial begin
    int                        waited;
    int                        gap;
    logic                      writes;
    logic [reg_addr_width-1:0] dst;
    logic [data_width-1:0]     value;
    logic [inst_width-1:0]     word;
    seed       = 32'h43c7;
    cycle      = 0;
    inst_valid = 1'b0;
    inst       = '0;
    for (int r = 0; r < 32; r++) begin
      ref_regs[r] = '0;
    end
    load_table();

    waited = 0;
    while (rst_n !== 1'b1 && waited < reset_timeout) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      fail("reset was never released");
    end

    // quiet pipeline after reset
    for (int i = 0; i < idle_cycles; i++) begin
      step(1'b0, '0);
      check("idle retire valid", 32'd0, {31'b0, retire.valid});
    end

    // bubbles keep the last word on inst with valid low
    foreach (tbl_inst[i]) begin
      step(1'b1, tbl_inst[i]);
      model_exec(tbl_inst[i], writes, dst, value);
      if (tbl_valid[i] != 0) begin
        expect_retire(tbl_name[i], tbl_rd[i], tbl_data[i]);
      end
      repeat (tbl_gap[i]) step(1'b0, tbl_inst[i]);
    end
    drain();

    // first half back to back, second half with gaps
    for (int i = 0; i < random_count; i++) begin
      word = random_inst();
      step(1'b1, word);
      model_exec(word, writes, dst, value);
      if (writes) begin
        expect_retire($sformatf("random %0d", i), dst, value);
      end
      gap = (i < random_count / 2) ? 0 : $unsigned($random(seed)) % 4;
      repeat (gap) step(1'b0, word);
    end
    drain();

    if (i_mini_core.i_core_properties.fail_count == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("%0d assertion failures", i_mini_core.i_core_properties.fail_count);
      $display("Regression failed");
      $fatal(1, "assertions failed");
    end
  end

endmodule

// File: flist.f
verilog/core_pkg.sv
verilog/pipe_reg.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/alu.sv
verilog/execute_stage.sv
verilog/mini_core.sv
test/clock_gen.sv
test/core_properties.sv
test/core_tb.sv

// File: Bender.yml
package:
  name: mini_core

dependencies: {}

sources:
  - files:
      - verilog/core_pkg.sv
      - verilog/pipe_reg.sv
      - verilog/register_file.sv
      - verilog/decode_stage.sv
      - verilog/alu.sv
      - verilog/execute_stage.sv
      - verilog/mini_core.sv
  - target: test
    files:
      - test/clock_gen.sv
      - test/core_properties.sv
      - test/core_tb.sv
